// ==== Makefile ====
TOP = tb_pick_best_intra4

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+.
vp8_pix_pkg.sv
vp8_mode_pkg.sv
i4_edge_rotate.sv
i4_predict.sv
i4_sse.sv
i4_mode_select.sv
i4_ctrl.sv
pick_best_intra4.sv
tb_pick_best_intra4.sv

// ==== i4_ctrl.sv ====
`timescale 1ns/1ps

module i4_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_i,
    input  logic                     sse_done_i,
    input  vp8_mode_pkg::i4_mode_e   best_mode_i,
    output vp8_pix_pkg::sub_idx_t    sub_idx_o,
    output logic                     init_o,
    output logic                     load_edges_o,
    output logic                     sse_start_o,
    output logic                     select_en_o,
    output logic                     store_o,
    output logic [63:0]              modes_o,
    output logic                     done_o
);
    import vp8_pix_pkg::*;
    import vp8_mode_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        EDGE,
        SSE,
        WAIT,
        SELECT,
        STORE,
        DONE
    } state_e;

    state_e state;
    state_e state_nxt;

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start_i) state_nxt = INIT;
            INIT:    state_nxt = EDGE;
            EDGE:    state_nxt = SSE;
            SSE:     state_nxt = WAIT;
            WAIT:    if (sse_done_i) state_nxt = SELECT;
            SELECT:  state_nxt = STORE;
            // Last subblock leaves the loop
            STORE:   state_nxt = (int'(sub_idx_o) == NUM_SUB - 1) ? DONE : EDGE;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            sub_idx_o <= '0;
            modes_o   <= '0;
        end else begin
            state <= state_nxt;
            if (state == INIT) begin
                sub_idx_o <= '0;
            end
            if (state == STORE) begin
                modes_o[4*sub_idx_o +: 4] <= {2'b00, best_mode_i};
                sub_idx_o                 <= sub_idx_o + 4'd1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Strobes
    // ------------------------------------------------------------------------
    assign init_o       = (state == INIT);
    assign load_edges_o = (state == EDGE);
    assign sse_start_o  = (state == SSE);
    assign select_en_o  = (state == SELECT);
    assign store_o      = (state == STORE);
    assign done_o       = (state == DONE);

    // Single done pulse right after the store that wraps the index
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> $past(store_o) && sub_idx_o == '0);

    a_sse_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        sse_done_i |-> state == WAIT);

endmodule

// ==== i4_edge_rotate.sv ====
`timescale 1ns/1ps

module i4_edge_rotate (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           init_i,
    input  logic                           load_edges_i,
    input  logic                           store_i,
    input  vp8_pix_pkg::sub_idx_t          sub_idx_i,
    input  vp8_pix_pkg::mb_t               src_i,
    input  vp8_pix_pkg::top_edge_t         top_i,
    input  vp8_pix_pkg::left_edge_t        left_i,
    input  vp8_pix_pkg::pix_t              top_left_i,
    input  vp8_pix_pkg::blk4_t             pred_i [vp8_mode_pkg::NUM_MODES],
    input  vp8_mode_pkg::i4_mode_e         best_mode_i,
    output vp8_pix_pkg::blk4_t             cur_src_o,
    output vp8_pix_pkg::row4_t             top_o,
    output vp8_pix_pkg::row4_t             top_right_o,
    output vp8_pix_pkg::row4_t             left_o,
    output vp8_pix_pkg::pix_t              corner_o,
    output vp8_pix_pkg::mb_t               yout_o
);
    import vp8_pix_pkg::*;
    import vp8_mode_pkg::*;

    mb_t   yout_q;
    blk4_t src_nxt;
    row4_t top_nxt;
    row4_t top_right_nxt;
    row4_t left_nxt;
    pix_t  corner_nxt;
    int    r;
    int    c;

    assign r = int'(sub_idx_i[3:2]);
    assign c = int'(sub_idx_i[1:0]);

    // ------------------------------------------------------------------------
    // Edge derivation for subblock (r,c)
    // ------------------------------------------------------------------------
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            src_nxt[32*k +: 32] = src_i[8*(16*(4*r+k) + 4*c) +: 32];
            if (c > 0) begin
                left_nxt[8*k +: 8] = yout_q[8*(16*(4*r+k) + 4*c - 1) +: 8];
            end else begin
                left_nxt[8*k +: 8] = left_i[8*(4*r+k) +: 8];
            end
        end

        if (r > 0) begin
            top_nxt = yout_q[8*(16*(4*r-1) + 4*c) +: 32];
        end else begin
            top_nxt = top_i[32*c +: 32];
        end

        if (r > 0 && c > 0) begin
            corner_nxt = yout_q[8*(16*(4*r-1) + 4*c - 1) +: 8];
        end else if (c > 0) begin
            corner_nxt = top_i[8*(4*c-1) +: 8];
        end else if (r > 0) begin
            corner_nxt = left_i[8*(4*r-1) +: 8];
        end else begin
            corner_nxt = top_left_i;
        end

        // Right column always borrows the macroblock's above-right samples
        if (c == 3) begin
            top_right_nxt = top_i[159:128];
        end else if (r == 0) begin
            top_right_nxt = top_i[32*(c+1) +: 32];
        end else begin
            top_right_nxt = yout_q[8*(16*(4*r-1) + 4*c + 4) +: 32];
        end
    end

    always_ff @(posedge clk) begin
        if (load_edges_i) begin
            cur_src_o   <= src_nxt;
            top_o       <= top_nxt;
            top_right_o <= top_right_nxt;
            left_o      <= left_nxt;
            corner_o    <= corner_nxt;
        end
        if (store_i) begin
            for (int k = 0; k < 4; k++) begin
                yout_q[8*(16*(4*r+k) + 4*c) +: 32] <= pred_i[best_mode_i][32*k +: 32];
            end
        end
    end

    assign yout_o = yout_q;

    // Store writes the subblock whose edges were used
    a_store_idx: assert property (@(posedge clk) disable iff (!rst_n)
        store_i |-> !init_i && !load_edges_i && $stable(sub_idx_i));

endmodule

// ==== i4_mode_select.sv ====
`timescale 1ns/1ps

module i4_mode_select (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      init_i,
    input  logic                      select_en_i,
    input  logic                      store_i,
    input  vp8_mode_pkg::sse_t        sse_i [vp8_mode_pkg::NUM_MODES],
    input  vp8_mode_pkg::lambda_t     lambda_i4_i,
    input  vp8_mode_pkg::lambda_t     lambda_mode_i,
    output vp8_mode_pkg::i4_mode_e    best_mode_o,
    output vp8_mode_pkg::score_t      score_o
);
    import vp8_mode_pkg::*;

    score_t   cand [NUM_MODES];
    score_t   best_score;
    i4_mode_e best_idx;
    score_t   lam_i4;
    score_t   lam_mode;

    assign lam_i4   = score_t'(lambda_i4_i);
    assign lam_mode = score_t'(lambda_mode_i);

    // Strict compare keeps the lower index on a tie
    always_comb begin
        best_score = '1;
        best_idx   = DC;
        for (int m = 0; m < NUM_MODES; m++) begin
            cand[m] = (score_t'(sse_i[m]) << 8) + score_t'(MODE_COST[m]) * lam_i4;
            if (m == 0 || cand[m] < best_score) begin
                best_score = cand[m];
                best_idx   = i4_mode_e'(m);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_mode_o <= DC;
            score_o     <= '0;
        end else begin
            if (select_en_i) begin
                best_mode_o <= best_idx;
            end
            if (init_i) begin
                score_o <= score_t'(MB_MODE_COST) * lam_mode;
            end else if (store_i) begin
                score_o <= score_o + (score_t'(sse_i[best_mode_o]) << 8)
                         + score_t'(MODE_COST[best_mode_o]) * lam_mode;
            end
        end
    end

    a_mode_known: assert property (@(posedge clk) disable iff (!rst_n)
        store_i |-> !$isunknown(best_mode_o));

endmodule

// ==== i4_predict.sv ====
`timescale 1ns/1ps

module i4_predict (
    input  vp8_pix_pkg::row4_t  top_i,
    input  vp8_pix_pkg::row4_t  top_right_i,
    input  vp8_pix_pkg::row4_t  left_i,
    input  vp8_pix_pkg::pix_t   corner_i,
    output vp8_pix_pkg::blk4_t  pred_o [vp8_mode_pkg::NUM_MODES]
);
    import vp8_pix_pkg::*;
    import vp8_mode_pkg::*;

    function automatic pix_t avg3(input pix_t a, input pix_t b, input pix_t c);
        logic [9:0] s;
        s = 10'(a) + 10'(2 * b) + 10'(c) + 10'd2;
        return s[9:2];
    endfunction

    pix_t       t [-1:4];
    pix_t       l [-1:4];
    pix_t       ve_row [4];
    logic [10:0] dc_sum;
    logic signed [10:0] tm;

    // Neighbour arrays padded with the corner and the far edge sample
    always_comb begin
        t[-1] = corner_i;
        l[-1] = corner_i;
        for (int k = 0; k < 4; k++) begin
            t[k] = top_i[8*k +: 8];
            l[k] = left_i[8*k +: 8];
        end
        t[4] = top_right_i[7:0];
        l[4] = left_i[31:24];
    end

    always_comb begin
        dc_sum = 11'd4;
        for (int k = 0; k < 4; k++) begin
            dc_sum = dc_sum + 11'(t[k]) + 11'(l[k]);
            ve_row[k] = avg3(t[k-1], t[k], t[k+1]);
        end

        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                pred_o[DC][8*(4*y+x) +: 8] = dc_sum[10:3];

                tm = 11'(l[y]) + 11'(t[x]) - 11'(corner_i);
                if (tm < 0) begin
                    pred_o[TM][8*(4*y+x) +: 8] = 8'd0;
                end else if (tm > 255) begin
                    pred_o[TM][8*(4*y+x) +: 8] = 8'd255;
                end else begin
                    pred_o[TM][8*(4*y+x) +: 8] = tm[7:0];
                end

                pred_o[VE][8*(4*y+x) +: 8] = ve_row[x];
                // Bottom row repeats L3 as its lower neighbour
                pred_o[HE][8*(4*y+x) +: 8] = avg3(l[y-1], l[y], l[y+1]);
            end
        end
    end

endmodule

// ==== i4_sse.sv ====
`timescale 1ns/1ps

module i4_sse #(
    parameter int SSE_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  vp8_pix_pkg::blk4_t   a_i,
    input  vp8_pix_pkg::blk4_t   b_i,
    output vp8_mode_pkg::sse_t   sse_o,
    output logic                 done_o
);
    import vp8_mode_pkg::*;

    localparam int BEATS = 16 / SSE_LANES;

    logic       busy;
    logic [4:0] cnt;
    logic [4:0] beat;
    sse_t       partial;
    sse_t       acc;

    // First beat is handled in the start cycle itself
    assign beat = start_i ? 5'd0 : cnt;

    always_comb begin
        logic signed [17:0] d;
        partial = '0;
        for (int k = 0; k < SSE_LANES; k++) begin
            d = $signed({1'b0, a_i[8*(int'(beat)*SSE_LANES + k) +: 8]})
              - $signed({1'b0, b_i[8*(int'(beat)*SSE_LANES + k) +: 8]});
            partial = partial + sse_t'(d * d);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            cnt    <= '0;
            acc    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i || busy) begin
                acc <= (start_i ? sse_t'(0) : acc) + partial;
                if (int'(beat) == BEATS - 1) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    cnt  <= beat + 5'd1;
                end
            end
        end
    end

    assign sse_o = acc;

endmodule

// ==== pick_best_intra4.sv ====
`timescale 1ns/1ps

module pick_best_intra4 #(
    parameter int SSE_LANES = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    input  vp8_pix_pkg::mb_t          src_i,
    input  vp8_pix_pkg::top_edge_t    top_i,
    input  vp8_pix_pkg::left_edge_t   left_i,
    input  vp8_pix_pkg::pix_t         top_left_i,
    input  vp8_mode_pkg::lambda_t     lambda_i4_i,
    input  vp8_mode_pkg::lambda_t     lambda_mode_i,
    output vp8_pix_pkg::mb_t          yout_o,
    output logic [63:0]               modes_o,
    output vp8_mode_pkg::score_t      score_o,
    output logic                      done_o
);
    import vp8_pix_pkg::*;
    import vp8_mode_pkg::*;

    sub_idx_t sub_idx;
    logic     init;
    logic     load_edges;
    logic     sse_start;
    logic     select_en;
    logic     store;
    logic     sse_done [NUM_MODES];
    sse_t     sse [NUM_MODES];
    blk4_t    pred [NUM_MODES];
    blk4_t    cur_src;
    row4_t    top;
    row4_t    top_right;
    row4_t    left;
    pix_t     corner;
    i4_mode_e best_mode;

    i4_ctrl u_i4_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .sse_done_i   (sse_done[0]),
        .best_mode_i  (best_mode),
        .sub_idx_o    (sub_idx),
        .init_o       (init),
        .load_edges_o (load_edges),
        .sse_start_o  (sse_start),
        .select_en_o  (select_en),
        .store_o      (store),
        .modes_o      (modes_o),
        .done_o       (done_o)
    );

    i4_edge_rotate u_i4_edge_rotate (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_i       (init),
        .load_edges_i (load_edges),
        .store_i      (store),
        .sub_idx_i    (sub_idx),
        .src_i        (src_i),
        .top_i        (top_i),
        .left_i       (left_i),
        .top_left_i   (top_left_i),
        .pred_i       (pred),
        .best_mode_i  (best_mode),
        .cur_src_o    (cur_src),
        .top_o        (top),
        .top_right_o  (top_right),
        .left_o       (left),
        .corner_o     (corner),
        .yout_o       (yout_o)
    );

    i4_predict u_i4_predict (
        .top_i       (top),
        .top_right_i (top_right),
        .left_i      (left),
        .corner_i    (corner),
        .pred_o      (pred)
    );

    // One SSE engine per candidate mode
    for (genvar m = 0; m < NUM_MODES; m++) begin : g_sse
        i4_sse #(
            .SSE_LANES (SSE_LANES)
        ) u_i4_sse (
            .clk     (clk),
            .rst_n   (rst_n),
            .start_i (sse_start),
            .a_i     (cur_src),
            .b_i     (pred[m]),
            .sse_o   (sse[m]),
            .done_o  (sse_done[m])
        );
    end

    i4_mode_select u_i4_mode_select (
        .clk           (clk),
        .rst_n         (rst_n),
        .init_i        (init),
        .select_en_i   (select_en),
        .store_i       (store),
        .sse_i         (sse),
        .lambda_i4_i   (lambda_i4_i),
        .lambda_mode_i (lambda_mode_i),
        .best_mode_o   (best_mode),
        .score_o       (score_o)
    );

endmodule

// ==== tb_intra4_model.svh ====
`ifndef TB_INTRA4_MODEL_SVH
`define TB_INTRA4_MODEL_SVH

// Expected results for the macroblock under test
int       exp_y [16][16];
i4_mode_e exp_mode [16];
score_t   exp_score;

function automatic int avg3(input int a, input int b, input int c);
    return (a + 2 * b + c + 2) / 4;
endfunction

// Raster search, edges taken from subblocks already decided
task automatic model_macroblock(input mb_t s, input top_edge_t te, input left_edge_t le,
                                input pix_t tl, input lambda_t li4, input lambda_t lm);
    int     cost [4];
    int     t [-1:4];
    int     l [-1:4];
    int     pr [4][4][4];
    longint sse [4];
    longint cand [4];
    int     dc;
    int     tm;
    int     d;
    int     r;
    int     c;
    int     bm;
    cost = '{40, 1151, 1723, 1874};
    exp_score = 211 * longint'(lm);
    for (int b = 0; b < 16; b++) begin
        r = b / 4;
        c = b % 4;
        for (int k = 0; k < 4; k++) begin
            t[k] = (r > 0) ? exp_y[4*r-1][4*c+k] : int'(te[8*(4*c+k) +: 8]);
            l[k] = (c > 0) ? exp_y[4*r+k][4*c-1] : int'(le[8*(4*r+k) +: 8]);
        end
        if (r > 0 && c > 0) begin
            t[-1] = exp_y[4*r-1][4*c-1];
        end else if (c > 0) begin
            t[-1] = int'(te[8*(4*c-1) +: 8]);
        end else if (r > 0) begin
            t[-1] = int'(le[8*(4*r-1) +: 8]);
        end else begin
            t[-1] = int'(tl);
        end
        // Only the first above-right sample feeds the kept predictors
        if (c == 3) begin
            t[4] = int'(te[8*16 +: 8]);
        end else begin
            t[4] = (r > 0) ? exp_y[4*r-1][4*c+4] : int'(te[8*(4*c+4) +: 8]);
        end
        l[-1] = t[-1];
        l[4]  = l[3];
        dc = 4;
        for (int k = 0; k < 4; k++) begin
            dc = dc + t[k] + l[k];
        end
        for (int m = 0; m < 4; m++) begin
            sse[m] = 0;
        end
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                tm = l[y] + t[x] - t[-1];
                pr[0][y][x] = dc / 8;
                pr[1][y][x] = (tm < 0) ? 0 : ((tm > 255) ? 255 : tm);
                pr[2][y][x] = avg3(t[x-1], t[x], t[x+1]);
                pr[3][y][x] = avg3(l[y-1], l[y], l[y+1]);
                for (int m = 0; m < 4; m++) begin
                    d = int'(s[8*(16*(4*r+y) + 4*c+x) +: 8]) - pr[m][y][x];
                    sse[m] = sse[m] + d * d;
                end
            end
        end
        bm = 0;
        for (int m = 0; m < 4; m++) begin
            cand[m] = (sse[m] << 8) + longint'(cost[m]) * longint'(li4);
            if (cand[m] < cand[bm]) begin
                bm = m;
            end
        end
        exp_mode[b] = i4_mode_e'(bm);
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                exp_y[4*r+y][4*c+x] = pr[bm][y][x];
            end
        end
        exp_score = exp_score + (sse[bm] << 8) + longint'(cost[bm]) * longint'(lm);
    end
endtask

function automatic blk4_t expected_block(input int b);
    blk4_t blk;
    for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
            blk[8*(4*y+x) +: 8] = 8'(exp_y[4*(b/4)+y][4*(b%4)+x]);
        end
    end
    return blk;
endfunction

`endif

// ==== tb_pick_best_intra4.sv ====
`timescale 1ns/1ps

module tb_pick_best_intra4;
    import vp8_pix_pkg::*;
    import vp8_mode_pkg::*;

    localparam int SSE_LANES  = 4;
    localparam int NUM_MB     = 25;
    localparam int LATENCY    = 2 + NUM_SUB * (16 / SSE_LANES + 4);
    localparam int MAX_CYCLES = (NUM_MB + 2) * LATENCY * 2;

    logic        clk;
    logic        rst_n;
    logic        start;
    mb_t         src;
    top_edge_t   top;
    left_edge_t  left;
    pix_t        top_left;
    lambda_t     lam_i4;
    lambda_t     lam_mode;
    mb_t         yout;
    logic [63:0] modes;
    score_t      score;
    logic        done;
    int          cycles = 0;
    int          errors = 0;

    `include "tb_intra4_model.svh"

    pick_best_intra4 #(
        .SSE_LANES (SSE_LANES)
    ) u_pick_best_intra4 (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start),
        .src_i         (src),
        .top_i         (top),
        .left_i        (left),
        .top_left_i    (top_left),
        .lambda_i4_i   (lam_i4),
        .lambda_mode_i (lam_mode),
        .yout_o        (yout),
        .modes_o       (modes),
        .score_o       (score),
        .done_o        (done)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: DUT did not finish within %0d cycles, %0d errors so far",
                     MAX_CYCLES, errors);
            $display("Verification failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_mode(input string name, input int b, input i4_mode_e exp,
                              input i4_mode_e act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s subblock %0d mode: expected %0d, actual %0d",
                     name, b, exp, act);
        end
    endtask

    task automatic check_block(input string name, input int b, input blk4_t exp,
                               input blk4_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s subblock %0d pixels: expected %h, actual %h",
                     name, b, exp, act);
        end
    endtask

    task automatic check_score(input string name, input score_t exp, input score_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s score: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic blk4_t sub_of(input mb_t m, input int b);
        blk4_t blk;
        for (int y = 0; y < 4; y++) begin
            blk[32*y +: 32] = m[8*(16*(4*(b/4)+y) + 4*(b%4)) +: 32];
        end
        return blk;
    endfunction

    task automatic compare_results(input string name);
        for (int b = 0; b < NUM_SUB; b++) begin
            check_mode(name, b, exp_mode[b], i4_mode_e'(modes[4*b +: 2]));
            if (modes[4*b+2 +: 2] !== 2'b00) begin
                errors++;
                $display("%s: mode field of subblock %0d has nonzero upper bits",
                         name, b);
            end
            check_block(name, b, expected_block(b), sub_of(yout, b));
        end
        check_score(name, exp_score, score);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic random_edges();
        for (int i = 0; i < 20; i++) begin
            top[8*i +: 8] = 8'($urandom_range(255, 0));
        end
        for (int i = 0; i < 16; i++) begin
            left[8*i +: 8] = 8'($urandom_range(255, 0));
        end
        top_left = 8'($urandom_range(255, 0));
        lam_i4   = lambda_t'($urandom_range(200, 1));
        lam_mode = lambda_t'($urandom_range(200, 1));
    endtask

    // Called 1 ns after a rising edge with the DUT idle
    task automatic run_mb(input string name, input bit restart);
        int waited;
        int extra;
        model_macroblock(src, top, left, top_left, lam_i4, lam_mode);
        start = 1'b1;
        @(posedge clk);
        #1;
        start  = 1'b0;
        waited = 0;
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
            waited++;
            start = restart && (waited == LATENCY / 2);
        end
        start = 1'b0;
        compare_results(name);
        if (restart) begin
            if (waited > LATENCY) begin
                errors++;
                $display("%s: done_o came %0d cycles after start, the busy start restarted",
                         name, waited);
            end
            extra = 0;
            repeat (LATENCY + 4) begin
                @(posedge clk);
                #1;
                if (done === 1'b1) begin
                    extra++;
                end
            end
            if (extra != 0) begin
                errors++;
                $display("%s: start pulsed while busy produced %0d extra done pulses",
                         name, extra);
            end
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        void'($urandom(25));
        clk      = 1'b0;
        rst_n    = 1'b0;
        start    = 1'b0;
        src      = '0;
        top      = '0;
        left     = '0;
        top_left = '0;
        lam_i4   = 1;
        lam_mode = 1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (3) begin
            if (done !== 1'b0) begin
                errors++;
                $display("done_o is not low after reset with no start");
            end
            check_score("reset", '0, score);
            @(posedge clk);
            #1;
        end

        // Flat macroblock, every candidate predicts 100
        src      = {256{8'd100}};
        top      = {20{8'd100}};
        left     = {16{8'd100}};
        top_left = 8'd100;
        lam_i4   = 37;
        lam_mode = 53;
        run_mb("flat", 1'b0);
        for (int b = 0; b < NUM_SUB; b++) begin
            check_mode("flat_rule", b, DC, i4_mode_e'(modes[4*b +: 2]));
            check_block("flat_rule", b, {16{8'd100}}, sub_of(yout, b));
        end
        check_score("flat_rule", score_t'(211 + 16 * 40) * score_t'(lam_mode), score);

        for (int n = 0; n < 20; n++) begin
            random_edges();
            for (int i = 0; i < 256; i++) begin
                src[8*i +: 8] = 8'($urandom_range(255, 0));
            end
            run_mb($sformatf("random_%0d", n), 1'b0);
        end

        random_edges();
        for (int y = 0; y < 16; y++) begin
            for (int x = 0; x < 16; x++) begin
                src[8*(16*y+x) +: 8] = top[8*x +: 8];
            end
        end
        run_mb("vertical", 1'b0);

        random_edges();
        for (int y = 0; y < 16; y++) begin
            for (int x = 0; x < 16; x++) begin
                src[8*(16*y+x) +: 8] = left[8*y +: 8];
            end
        end
        run_mb("horizontal", 1'b0);

        // Same inputs twice, second run gets a stray start
        random_edges();
        for (int i = 0; i < 256; i++) begin
            src[8*i +: 8] = 8'($urandom_range(255, 0));
        end
        run_mb("first_run", 1'b0);
        run_mb("restart_mid", 1'b1);

        $display("Finished %0d macroblocks with %0d errors", NUM_MB, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== vp8_mode_pkg.sv ====
package vp8_mode_pkg;

    // ------------------------------------------------------------------------
    // Intra 4x4 modes kept in this search
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        DC = 2'd0,
        TM = 2'd1,
        VE = 2'd2,
        HE = 2'd3
    } i4_mode_e;

    localparam int NUM_MODES = 4;

    // Header bits per mode, scaled by lambda
    localparam logic [15:0] MODE_COST [NUM_MODES] = '{16'd40, 16'd1151, 16'd1723, 16'd1874};

    // Macroblock header cost for the i4 path
    localparam logic [15:0] MB_MODE_COST = 16'd211;

    typedef logic [31:0] sse_t;
    typedef logic [63:0] score_t;
    typedef logic signed [31:0] lambda_t;

endpackage

// ==== vp8_pix_pkg.sv ====
package vp8_pix_pkg;

    // ------------------------------------------------------------------------
    // Luma sample containers
    // ------------------------------------------------------------------------

    // One 8-bit luma sample
    typedef logic [7:0] pix_t;

    // Four samples of a subblock row, leftmost in the low byte
    typedef logic [31:0] row4_t;

    // 4x4 subblock, top row at the low end
    typedef logic [127:0] blk4_t;

    // 16x16 macroblock in raster order, sample (y,x) at byte 16y+x
    typedef logic [2047:0] mb_t;

    // ------------------------------------------------------------------------
    // Macroblock edges and geometry
    // ------------------------------------------------------------------------

    // 16 samples above plus 4 above-right
    typedef logic [159:0] top_edge_t;
    typedef logic [127:0] left_edge_t;

    typedef logic [3:0] sub_idx_t;

    localparam int NUM_SUB = 16;

endpackage
